// File: test/usbPe_cases.txt
# name kind endpoint keepPacket length, then eight payload bytes in hex
# badToken rows carry the PID byte to send in the first payload column
outEp1         out      1  1 4 11 22 33 44 00 00 00 00
outEp3         out      3  1 8 a0 a1 a2 a3 a4 a5 a6 a7
outEp2Single   out      2  1 1 5a 00 00 00 00 00 00 00
outBadEp2      outBad   2  0 3 de ad be 00 00 00 00 00
outAfterBad    out      2  1 3 c0 ff ee 00 00 00 00 00
inEp2          in       2  1 5 10 20 30 40 50 00 00 00
inEp1Single    in       1  1 1 99 00 00 00 00 00 00 00
inEmptyEp3     inEmpty  3  1 0 00 00 00 00 00 00 00 00
outAfterInE    out      3  1 2 77 88 00 00 00 00 00 00
inEp3Long      in       3  1 8 f0 f1 f2 f3 f4 f5 f6 f7
badCheckOut    badToken 1  1 1 11 00 00 00 00 00 00 00
badEp0In       badToken 0  1 1 69 00 00 00 00 00 00 00
badEp0Out      badToken 0  1 1 e1 00 00 00 00 00 00 00
badEp4In       badToken 4  1 1 69 00 00 00 00 00 00 00
badEp15Out     badToken 15 1 1 e1 00 00 00 00 00 00 00
outAfterBadTok out      1  1 4 01 02 03 04 00 00 00 00
timeoutToken   timeout  2  1 0 00 00 00 00 00 00 00 00
outAfterTo     out      2  1 2 ab cd 00 00 00 00 00 00
timeoutData    timeout  1  1 3 31 32 33 00 00 00 00 00
outAfterToData out      1  1 3 41 42 43 00 00 00 00 00
outBadEp1      outBad   1  0 2 e5 e6 00 00 00 00 00 00
outAfterBad1   out      1  1 5 61 62 63 64 65 00 00 00
inEp2Again     in       2  1 3 0a 0b 0c 00 00 00 00 00

// File: filelist.f
+incdir+include
logic/usbPePkg.sv
logic/epFifo.sv
logic/usbTimeout.sv
logic/endpointBank.sv
logic/tokenCapture.sv
logic/usbPe.sv
test/usbPeTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module usbPeTb -o usbPeSim \
    && ./obj_dir/usbPeSim > sim.log 2>&1 \
    && ! grep -q "sim failed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: test/usbPeTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module usbPeTb;

    localparam int WaitLimit = 400;
    localparam int MaxBytes = 8;

    logic                                   clk48;
    logic                                   arstN;
    usbPePkg::rxByteT                       rxByte;
    logic                                   keepPacket;
    logic                                   rxGotSignal;
    logic                                   rxAccept;
    usbPePkg::txByteT                       txByte;
    logic                                   txReq;
    logic                                   txAccept;
    logic                                   sending;
    usbPePkg::epUserT [`EP_COUNT-1:0]       epOutUser;
    logic [`EP_COUNT-1:0]                   epOutPop;
    logic [`EP_COUNT-1:0][`EP_DATA_WID-1:0] epInData;
    logic [`EP_COUNT-1:0]                   epInValid;
    logic [`EP_COUNT-1:0]                   epInLast;
    logic [`EP_COUNT-1:0]                   epInCommit;
    logic [`EP_COUNT-1:0]                   epInFull;

    int errCount;
    int toCount;
    int caseCount;

    // Current row of the case file
    logic [8*16-1:0] caseName;
    logic [8*16-1:0] caseKind;
    int              caseEp;
    int              caseKeep;
    int              caseLen;
    logic [7:0]      payload [MaxBytes];

    usbPe i_usbPe (
        .clk48_i(clk48),
        .arstN_i(arstN),
        .rxByte_i(rxByte),
        .keepPacket_i(keepPacket),
        .rxDPPLGotSignal_i(rxGotSignal),
        .rxAcceptNewData_o(rxAccept),
        .txByte_o(txByte),
        .txReqSendPacket_o(txReq),
        .txAcceptNewData_i(txAccept),
        .isSendingPhase_o(sending),
        .epOutUser_o(epOutUser),
        .epOutPop_i(epOutPop),
        .epInData_i(epInData),
        .epInValid_i(epInValid),
        .epInLast_i(epInLast),
        .epInCommit_i(epInCommit),
        .epInFull_o(epInFull)
    );

    // 25 MHz stand-in for the 48 MHz clock
    initial begin
        clk48 = 1'b0;
        forever #20 clk48 = ~clk48;
    end

    // ==============================
    // Checks
    // ==============================

    task automatic compareFlag(input string what, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("Fail %0s %0s: expected %b actual %b", caseName, what, expVal, actVal);
        end
    endtask

    task automatic compareUserByte(input string what, input usbPePkg::epUserT expVal,
                                   input usbPePkg::epUserT actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("Fail %0s %0s: expected data %h avail %b last %b actual data %h avail %b last %b",
                caseName, what, expVal.data, expVal.available, expVal.isLast,
                actVal.data, actVal.available, actVal.isLast);
        end
    endtask

    task automatic compareTxByte(input string what, input usbPePkg::txByteT expVal,
                                 input usbPePkg::txByteT actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("Fail %0s %0s: expected data %h valid %b last %b actual data %h valid %b last %b",
                caseName, what, expVal.data, expVal.valid, expVal.isLast,
                actVal.data, actVal.valid, actVal.isLast);
        end
    endtask

    task automatic reportTimeout(input string what);
        toCount++;
        $display("Timeout in %0s: %0s did not happen within %0d cycles", caseName, what, WaitLimit);
    endtask

    task automatic checkNoneAvailable(input string what);
        for (int k = 0; k < `EP_COUNT; k++) begin
            compareFlag($sformatf("%0s ep%0d available", what, k + 1), 1'b0, epOutUser[k].available);
        end
    endtask

    // No transmit activity, plus the token wait levels when asked
    task automatic watchQuiet(input int cycles, input logic inTokenWait);
        repeat (cycles) begin
            compareFlag("transmit request", 1'b0, txReq);
            compareFlag("transmit valid", 1'b0, txByte.valid);
            if (inTokenWait) begin
                compareFlag("sending phase", 1'b0, sending);
                compareFlag("receive accept", 1'b1, rxAccept);
            end
            @(negedge clk48);
        end
    endtask

    // ==============================
    // Bus stimulus
    // ==============================

    // Starts and ends on a falling edge
    task automatic sendByte(input logic [7:0] data, input logic last);
        int gap;
        int waitCnt;
        gap = $urandom_range(2);
        repeat (gap) @(negedge clk48);
        rxByte.data = data;
        rxByte.valid = 1'b1;
        rxByte.isLast = last;
        waitCnt = 0;
        while (!rxAccept && waitCnt < WaitLimit) begin
            @(negedge clk48);
            waitCnt++;
        end
        if (!rxAccept) begin
            reportTimeout("receive accept");
        end
        @(negedge clk48);
        rxByte.valid = 1'b0;
        rxByte.isLast = 1'b0;
    endtask

    // Random address and CRC since the engine checks neither
    task automatic sendToken(input logic [7:0] pidByte, input int ep);
        logic [23:0] tok;
        tok = {5'($urandom), 4'(ep), 7'($urandom), pidByte};
        rxGotSignal = 1'b1;
        sendByte(tok[7:0], 1'b0);
        sendByte(tok[15:8], 1'b0);
        sendByte(tok[23:16], 1'b1);
        rxGotSignal = 1'b0;
    endtask

    // DATA0 then the payload
    task automatic sendData(input int count, input logic last);
        rxGotSignal = 1'b1;
        sendByte(8'hc3, 1'b0);
        for (int i = 0; i < count; i++) begin
            sendByte(payload[i], last && i == count - 1);
        end
        rxGotSignal = 1'b0;
    endtask

    task automatic preloadIn();
        for (int k = 0; k < caseLen; k++) begin
            epInData[caseEp-1] = payload[k];
            epInValid[caseEp-1] = 1'b1;
            epInLast[caseEp-1] = k == caseLen - 1;
            epInCommit[caseEp-1] = k == caseLen - 1;
            @(negedge clk48);
        end
        epInValid = '0;
        epInLast = '0;
        epInCommit = '0;
    endtask

    task automatic readOut();
        int               waitCnt;
        usbPePkg::epUserT expUser;
        waitCnt = 0;
        while (!epOutUser[caseEp-1].available && waitCnt < WaitLimit) begin
            @(negedge clk48);
            waitCnt++;
        end
        if (!epOutUser[caseEp-1].available) begin
            reportTimeout("OUT data available");
        end
        for (int k = 0; k < `EP_COUNT; k++) begin
            if (k != caseEp - 1) begin
                compareFlag($sformatf("other ep%0d available", k + 1), 1'b0,
                    epOutUser[k].available);
            end
        end
        for (int k = 0; k < caseLen; k++) begin
            expUser.data = payload[k];
            expUser.available = 1'b1;
            expUser.isLast = k == caseLen - 1;
            compareUserByte($sformatf("OUT byte %0d", k), expUser, epOutUser[caseEp-1]);
            epOutPop[caseEp-1] = 1'b1;
            @(negedge clk48);
            epOutPop[caseEp-1] = 1'b0;
        end
        compareFlag("available after last pop", 1'b0, epOutUser[caseEp-1].available);
    endtask

    // Transmitter model with random stalls
    task automatic readIn();
        int               waitCnt;
        int               stall;
        usbPePkg::txByteT expTx;
        waitCnt = 0;
        while (!txReq && waitCnt < WaitLimit) begin
            @(negedge clk48);
            waitCnt++;
        end
        if (!txReq) begin
            reportTimeout("transmit request");
        end
        // Receiver closed while the packet goes out
        compareFlag("sending phase during transfer", 1'b1, sending);
        compareFlag("receive accept during transfer", 1'b0, rxAccept);
        for (int k = 0; k < caseLen; k++) begin
            stall = $urandom_range(2);
            repeat (stall) begin
                compareFlag("request held in stall", 1'b1, txReq);
                @(negedge clk48);
            end
            expTx.data = payload[k];
            expTx.valid = 1'b1;
            expTx.isLast = k == caseLen - 1;
            compareTxByte($sformatf("IN byte %0d", k), expTx, txByte);
            txAccept = 1'b1;
            @(negedge clk48);
            txAccept = 1'b0;
        end
        compareFlag("sending phase after last byte", 1'b0, sending);
        compareFlag("request after last byte", 1'b0, txReq);
    endtask

    task automatic runCase();
        keepPacket = caseKeep != 0;
        if (caseKind == "out" || caseKind == "outBad") begin
            sendToken(8'he1, caseEp);
            sendData(caseLen, 1'b1);
            if (caseKeep != 0) begin
                readOut();
            end else begin
                repeat (4) @(negedge clk48);
                checkNoneAvailable("dropped packet");
            end
        end else if (caseKind == "in") begin
            preloadIn();
            sendToken(8'h69, caseEp);
            readIn();
        end else if (caseKind == "inEmpty") begin
            sendToken(8'h69, caseEp);
            watchQuiet(8, 1'b0);
            compareFlag("sending phase after empty IN", 1'b0, sending);
        end else if (caseKind == "badToken") begin
            // PID byte comes from the first payload column
            sendToken(payload[0], caseEp);
            watchQuiet(8, 1'b1);
            checkNoneAvailable("rejected token");
        end else if (caseKind == "timeout") begin
            sendToken(8'he1, caseEp);
            if (caseLen > 0) begin
                // Partial packet that never ends
                sendData(caseLen, 1'b0);
            end
            repeat ((`TIMEOUT_BITS + 4) * 4) @(negedge clk48);
            checkNoneAvailable("after timeout");
        end else begin
            errCount++;
            $display("Unknown test kind %0s in case %0s", caseKind, caseName);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin : mainFlow
        int    fd;
        int    nRead;
        string line;
        void'($urandom(32'hdd87_f131));
        errCount = 0;
        toCount = 0;
        caseCount = 0;
        caseName = "reset";
        arstN = 1'b0;
        rxByte = '0;
        keepPacket = 1'b0;
        rxGotSignal = 1'b0;
        txAccept = 1'b0;
        epOutPop = '0;
        epInData = '0;
        epInValid = '0;
        epInLast = '0;
        epInCommit = '0;
        repeat (10) @(negedge clk48);
        arstN = 1'b1;
        @(negedge clk48);

        // Quiet outputs out of reset
        compareFlag("transmit request", 1'b0, txReq);
        compareFlag("transmit valid", 1'b0, txByte.valid);
        compareFlag("sending phase", 1'b0, sending);
        checkNoneAvailable("reset");
        for (int k = 0; k < `EP_COUNT; k++) begin
            compareFlag($sformatf("ep%0d IN full", k + 1), 1'b0, epInFull[k]);
        end

        fd = $fopen("test/usbPe_cases.txt", "r");
        if (fd == 0) begin
            errCount++;
            $display("Could not open the case file test/usbPe_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                nRead = $fgets(line, fd);
                if (nRead > 0 && line.len() > 1 && line[0] != "#") begin
                    nRead = $sscanf(line, "%s %s %d %d %d %h %h %h %h %h %h %h %h",
                        caseName, caseKind, caseEp, caseKeep, caseLen,
                        payload[0], payload[1], payload[2], payload[3],
                        payload[4], payload[5], payload[6], payload[7]);
                    if (nRead != 13) begin
                        errCount++;
                        $display("Malformed line in the case file: %0s", line);
                    end else begin
                        caseCount++;
                        runCase();
                    end
                end
            end
            $fclose(fd);
        end
        if (caseCount == 0) begin
            errCount++;
            $display("No test case was run");
        end

        $display("Summary: %0d cases, %0d mismatches, %0d timeouts", caseCount, errCount, toCount);
        if (errCount == 0 && toCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/usbPe.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module usbPe (
    input  wire                                   clk48_i,
    input  wire                                   arstN_i,
    // Serial receiver
    input  wire usbPePkg::rxByteT                 rxByte_i,
    input  wire                                   keepPacket_i,
    input  wire                                   rxDPPLGotSignal_i,
    output logic                                  rxAcceptNewData_o,
    // Serial transmitter
    output usbPePkg::txByteT                      txByte_o,
    output logic                                  txReqSendPacket_o,
    input  wire                                   txAcceptNewData_i,
    output logic                                  isSendingPhase_o,
    // Endpoint user side, index 0 is endpoint 1
    output usbPePkg::epUserT [`EP_COUNT-1:0]      epOutUser_o,
    input  wire [`EP_COUNT-1:0]                   epOutPop_i,
    input  wire [`EP_COUNT-1:0][`EP_DATA_WID-1:0] epInData_i,
    input  wire [`EP_COUNT-1:0]                   epInValid_i,
    input  wire [`EP_COUNT-1:0]                   epInLast_i,
    input  wire [`EP_COUNT-1:0]                   epInCommit_i,
    output logic [`EP_COUNT-1:0]                  epInFull_o
);

    usbPePkg::epWriteT      epWrite;
    usbPePkg::epCommitT     epCommit;
    logic [`EP_SEL_WID-1:0] epSel;
    logic                   rxFifoFull;
    usbPePkg::txByteT       txHead;
    logic                   txPop;
    logic                   timerRestart;
    logic                   timeout;

    // ==============================
    // Token receive logic
    // ==============================

    tokenCapture i_tokenCapture (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .rxByte_i(rxByte_i),
        .keepPacket_i(keepPacket_i),
        .rxAcceptNewData_o(rxAcceptNewData_o),
        .epWrite_o(epWrite),
        .epCommit_o(epCommit),
        .epSel_o(epSel),
        .rxFifoFull_i(rxFifoFull),
        .txHead_i(txHead),
        .txAcceptNewData_i(txAcceptNewData_i),
        .txPop_o(txPop),
        .txByte_o(txByte_o),
        .txReqSendPacket_o(txReqSendPacket_o),
        .isSendingPhase_o(isSendingPhase_o),
        .timerRestart_o(timerRestart),
        .timeout_i(timeout)
    );

    // ==============================
    // Endpoint bank
    // ==============================

    endpointBank i_endpointBank (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .epWrite_i(epWrite),
        .epCommit_i(epCommit),
        .epSel_i(epSel),
        .rxFifoFull_o(rxFifoFull),
        .txHead_o(txHead),
        .txPop_i(txPop),
        .epOutUser_o(epOutUser_o),
        .epOutPop_i(epOutPop_i),
        .epInData_i(epInData_i),
        .epInValid_i(epInValid_i),
        .epInLast_i(epInLast_i),
        .epInCommit_i(epInCommit_i),
        .epInFull_o(epInFull_o)
    );

    // Host silence after an OUT token
    usbTimeout i_usbTimeout (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .restart_i(timerRestart),
        .rxGotSignal_i(rxDPPLGotSignal_i),
        .timeout_o(timeout)
    );

endmodule

`default_nettype wire

// File: logic/tokenCapture.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module tokenCapture (
    input  wire                         clk48_i,
    input  wire                         arstN_i,
    input  wire usbPePkg::rxByteT       rxByte_i,
    input  wire                         keepPacket_i,
    output logic                        rxAcceptNewData_o,
    output usbPePkg::epWriteT           epWrite_o,
    output usbPePkg::epCommitT          epCommit_o,
    output logic [`EP_SEL_WID-1:0]      epSel_o,
    input  wire                         rxFifoFull_i,
    input  wire usbPePkg::txByteT       txHead_i,
    input  wire                         txAcceptNewData_i,
    output logic                        txPop_o,
    output usbPePkg::txByteT            txByte_o,
    output logic                        txReqSendPacket_o,
    output logic                        isSendingPhase_o,
    output logic                        timerRestart_o,
    input  wire                         timeout_i
);

    typedef enum logic [1:0] {
        TokenWait,
        OutPid,
        OutData,
        InSend
    } stateT;

    stateT                  state;
    stateT                  stateNext;
    logic [2:0]             byteCnt;
    usbPePkg::tokenBufT     tokenBuf;
    usbPePkg::tokenBufT     tokenNext;
    logic [`EP_SEL_WID-1:0] epSel;
    logic                   outPhase;
    logic                   rxAcc;
    logic                   rxLastAcc;
    logic                   tokenOk;
    logic                   badDataPid;

    // ==============================
    // Receive handshake
    // ==============================

    assign outPhase = state == OutPid || state == OutData;

    // Tokens always taken, OUT payload only with room
    assign rxAcceptNewData_o = state == TokenWait || (outPhase && !rxFifoFull_i);
    assign rxAcc = rxAcceptNewData_o && rxByte_i.valid;
    assign rxLastAcc = rxAcc && rxByte_i.isLast;

    // Covers the entry to OUT too, since that is the last token byte
    assign timerRestart_o = rxAcc;

    // Buffer as it will look with the current byte in it
    always_comb begin
        tokenNext = tokenBuf;
        if (byteCnt < 3'(`TOKEN_BYTES)) begin
            tokenNext.raw[byteCnt[1:0]] = rxByte_i.data;
        end
    end

    // Exactly three bytes, intact PID, endpoint in range
    // Address field decoded but not compared
    assign tokenOk = byteCnt == 3'(`TOKEN_BYTES - 1)
        && tokenNext.fields.pidCheck == ~tokenNext.fields.pid
        && tokenNext.fields.endp != '0
        && tokenNext.fields.endp <= `EP_COUNT;

    // ==============================
    // Transaction FSM
    // ==============================

    always_comb begin
        stateNext = state;
        badDataPid = 1'b0;
        case (state)
            TokenWait: begin
                if (rxLastAcc && tokenOk) begin
                    if (tokenNext.fields.pid == usbPePkg::PidOut) begin
                        stateNext = OutPid;
                    end else if (tokenNext.fields.pid == usbPePkg::PidIn) begin
                        stateNext = InSend;
                    end
                end
            end
            OutPid: begin
                if (timeout_i) begin
                    stateNext = TokenWait;
                end else if (rxAcc) begin
                    // First byte must be a data PID
                    badDataPid = rxByte_i.data[3:0] != usbPePkg::PidData0
                        && rxByte_i.data[3:0] != usbPePkg::PidData1;
                    stateNext = (rxByte_i.isLast || badDataPid) ? TokenWait : OutData;
                end
            end
            OutData: begin
                if (timeout_i || rxLastAcc) begin
                    stateNext = TokenWait;
                end
            end
            default: begin
                // Nothing committed means nothing to send
                if (!txHead_i.valid || (txPop_o && txHead_i.isLast)) begin
                    stateNext = TokenWait;
                end
            end
        endcase
    end

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= TokenWait;
            byteCnt <= '0;
            epSel <= '0;
        end else begin
            state <= stateNext;
            if (state == TokenWait && rxAcc) begin
                if (rxByte_i.isLast) begin
                    byteCnt <= '0;
                end else if (~&byteCnt) begin
                    byteCnt <= byteCnt + 1'b1;
                end
                if (rxByte_i.isLast && tokenOk) begin
                    epSel <= tokenNext.fields.endp;
                end
            end
        end
    end

    // Token bytes
    always_ff @(posedge clk48_i) begin
        if (state == TokenWait && rxAcc) begin
            tokenBuf <= tokenNext;
        end
    end

    // ==============================
    // Endpoint steering
    // ==============================

    assign epSel_o = epSel;

    always_comb begin
        epWrite_o.epNum = epSel;
        epWrite_o.wrEn = state == OutData && rxAcc;
        epWrite_o.data = rxByte_i.data;
        epWrite_o.isLast = rxByte_i.isLast;

        // Keep on a good last byte, rewind on timeout or bad PID
        epCommit_o.done = outPhase && (timeout_i || rxLastAcc || badDataPid);
        epCommit_o.success = rxLastAcc && keepPacket_i && !badDataPid && !timeout_i;
    end

    always_comb begin
        txByte_o.data = txHead_i.data;
        txByte_o.isLast = txHead_i.isLast;
        txByte_o.valid = state == InSend && txHead_i.valid;
    end

    // Request held until the last byte leaves
    assign txReqSendPacket_o = txByte_o.valid;
    assign txPop_o = txByte_o.valid && txAcceptNewData_i;
    assign isSendingPhase_o = state == InSend;

endmodule

`default_nettype wire

// File: logic/endpointBank.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module endpointBank (
    input  wire                                       clk48_i,
    input  wire                                       arstN_i,
    input  wire usbPePkg::epWriteT                    epWrite_i,
    input  wire usbPePkg::epCommitT                   epCommit_i,
    input  wire [`EP_SEL_WID-1:0]                     epSel_i,
    output logic                                      rxFifoFull_o,
    output usbPePkg::txByteT                          txHead_o,
    input  wire                                       txPop_i,
    output usbPePkg::epUserT [`EP_COUNT-1:0]          epOutUser_o,
    input  wire [`EP_COUNT-1:0]                       epOutPop_i,
    input  wire [`EP_COUNT-1:0][`EP_DATA_WID-1:0]     epInData_i,
    input  wire [`EP_COUNT-1:0]                       epInValid_i,
    input  wire [`EP_COUNT-1:0]                       epInLast_i,
    input  wire [`EP_COUNT-1:0]                       epInCommit_i,
    output logic [`EP_COUNT-1:0]                      epInFull_o
);

    logic [`EP_COUNT-1:0]                   rxFull;
    logic [`EP_COUNT-1:0]                   txAvail;
    logic [`EP_COUNT-1:0]                   txLast;
    logic [`EP_COUNT-1:0][`EP_DATA_WID-1:0] txData;

    // Index 0 holds endpoint 1
    for (genvar i = 0; i < `EP_COUNT; i++) begin : g_ep
        logic               isWrSel;
        logic               isSel;
        usbPePkg::epCommitT rxCommit;
        usbPePkg::epCommitT inCommit;

        assign isWrSel = epWrite_i.epNum == i + 1;
        assign isSel = epSel_i == i + 1;
        assign rxCommit = '{done: epCommit_i.done && isWrSel, success: epCommit_i.success};

        // User side has no way to abort a packet
        assign inCommit = '{done: epInCommit_i[i], success: 1'b1};

        // Host to device
        epFifo #(
            .DEPTH_LOG2(`FIFO_DEPTH_LOG2)
        ) i_rxFifo (
            .clk48_i(clk48_i),
            .arstN_i(arstN_i),
            .wrEn_i(epWrite_i.wrEn && isWrSel),
            .wrData_i(epWrite_i.data),
            .wrLast_i(epWrite_i.isLast),
            .commit_i(rxCommit),
            .rdEn_i(epOutPop_i[i]),
            .rdData_o(epOutUser_o[i].data),
            .rdLast_o(epOutUser_o[i].isLast),
            .rdAvail_o(epOutUser_o[i].available),
            .full_o(rxFull[i])
        );

        // Device to host
        epFifo #(
            .DEPTH_LOG2(`FIFO_DEPTH_LOG2)
        ) i_txFifo (
            .clk48_i(clk48_i),
            .arstN_i(arstN_i),
            .wrEn_i(epInValid_i[i]),
            .wrData_i(epInData_i[i]),
            .wrLast_i(epInLast_i[i]),
            .commit_i(inCommit),
            .rdEn_i(txPop_i && isSel),
            .rdData_o(txData[i]),
            .rdLast_o(txLast[i]),
            .rdAvail_o(txAvail[i]),
            .full_o(epInFull_o[i])
        );
    end

    // Selected endpoint back to capture
    // Out of range selection reads as empty and not full
    always_comb begin
        rxFifoFull_o = 1'b0;
        txHead_o = '0;
        for (int k = 0; k < `EP_COUNT; k++) begin
            if (epSel_i == k + 1) begin
                rxFifoFull_o = rxFull[k];
                txHead_o.data = txData[k];
                txHead_o.valid = txAvail[k];
                txHead_o.isLast = txLast[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/usbTimeout.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module usbTimeout (
    input  wire  clk48_i,
    input  wire  arstN_i,
    input  wire  restart_i,
    input  wire  rxGotSignal_i,
    output logic timeout_o
);

    localparam int CntWid = $clog2(`TIMEOUT_BITS + 1);

    logic [1:0]        div;
    logic              bitEn;
    logic [CntWid-1:0] bitCnt;

    // One bit time every 4 clocks at 48 MHz
    assign bitEn = &div;

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            div <= '0;
            bitCnt <= '0;
            timeout_o <= 1'b0;
        end else begin
            div <= div + 1'b1;
            timeout_o <= 1'b0;
            // Line activity or a new wait starts over
            if (restart_i || rxGotSignal_i) begin
                bitCnt <= '0;
            end else if (bitEn && bitCnt != CntWid'(`TIMEOUT_BITS)) begin
                bitCnt <= bitCnt + 1'b1;
                // Single pulse, then the count parks at the limit
                timeout_o <= bitCnt == CntWid'(`TIMEOUT_BITS - 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/epFifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "usbPe_defines.svh"

module epFifo #(
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
    input  wire                          clk48_i,
    input  wire                          arstN_i,
    input  wire                          wrEn_i,
    input  wire [`EP_DATA_WID-1:0]       wrData_i,
    input  wire                          wrLast_i,
    input  wire usbPePkg::epCommitT      commit_i,
    input  wire                          rdEn_i,
    output logic [`EP_DATA_WID-1:0]      rdData_o,
    output logic                         rdLast_o,
    output logic                         rdAvail_o,
    output logic                         full_o
);

    localparam int Depth = 2 ** DEPTH_LOG2;

    // Extra MSB tells full from empty
    logic [DEPTH_LOG2:0]   wrPtr;
    logic [DEPTH_LOG2:0]   wrNext;
    logic [DEPTH_LOG2:0]   cmtPtr;
    logic [DEPTH_LOG2:0]   cmtPtrRd;
    logic [DEPTH_LOG2:0]   rdPtr;
    logic [`EP_DATA_WID:0] mem [Depth];
    logic                  doWrite;
    logic                  doRead;

    // Writer may run up to the reader, not just the commit point
    assign full_o = wrPtr[DEPTH_LOG2] != rdPtr[DEPTH_LOG2]
        && wrPtr[DEPTH_LOG2-1:0] == rdPtr[DEPTH_LOG2-1:0];

    // Reader sees committed bytes one cycle after the commit
    assign rdAvail_o = cmtPtrRd != rdPtr;

    assign doWrite = wrEn_i && !full_o;
    assign doRead = rdEn_i && rdAvail_o;
    assign wrNext = wrPtr + {{DEPTH_LOG2{1'b0}}, doWrite};

    // Flag stored above the byte
    assign rdData_o = mem[rdPtr[DEPTH_LOG2-1:0]][`EP_DATA_WID-1:0];
    assign rdLast_o = mem[rdPtr[DEPTH_LOG2-1:0]][`EP_DATA_WID];

    always_ff @(posedge clk48_i) begin
        if (doWrite) begin
            mem[wrPtr[DEPTH_LOG2-1:0]] <= {wrLast_i, wrData_i};
        end
    end

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr <= '0;
            cmtPtr <= '0;
            cmtPtrRd <= '0;
            rdPtr <= '0;
        end else begin
            cmtPtrRd <= cmtPtr;
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Failed packet drops every byte since the last commit
            if (commit_i.done && !commit_i.success) begin
                wrPtr <= cmtPtr;
            end else begin
                wrPtr <= wrNext;
            end
            // Byte written with the commit belongs to the packet
            if (commit_i.done && commit_i.success) begin
                cmtPtr <= wrNext;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/usbPePkg.sv
`default_nettype none
`include "usbPe_defines.svh"

package usbPePkg;

    // Only the PIDs the engine acts on
    typedef enum logic [3:0] {
        PidOut   = 4'b0001,
        PidIn    = 4'b1001,
        PidData0 = 4'b0011,
        PidData1 = 4'b1011
    } pidT;

    // Token fields, LSB first on the wire so byte 0 sits at the bottom
    typedef struct packed {
        logic [4:0]             crc5;
        logic [`EP_SEL_WID-1:0] endp;
        logic [6:0]             addr;
        logic [3:0]             pidCheck;
        pidT                    pid;
    } tokenFieldsT;

    // Filled bytewise, read as fields
    typedef union packed {
        logic [`TOKEN_BYTES-1:0][`EP_DATA_WID-1:0] raw;
        tokenFieldsT                               fields;
    } tokenBufT;

    // Byte from the serial receiver
    typedef struct packed {
        logic [`EP_DATA_WID-1:0] data;
        logic                    valid;
        logic                    isLast;
    } rxByteT;

    // Byte to the serial transmitter
    typedef struct packed {
        logic [`EP_DATA_WID-1:0] data;
        logic                    valid;
        logic                    isLast;
    } txByteT;

    typedef struct packed {
        logic [`EP_SEL_WID-1:0]  epNum;
        logic                    wrEn;
        logic [`EP_DATA_WID-1:0] data;
        logic                    isLast;
    } epWriteT;

    // Ends a packet by keeping or dropping it
    typedef struct packed {
        logic done;
        logic success;
    } epCommitT;

    typedef struct packed {
        logic [`EP_DATA_WID-1:0] data;
        logic                    available;
        logic                    isLast;
    } epUserT;

endpackage

`default_nettype wire

// File: include/usbPe_defines.svh
`ifndef USBPE_DEFINES_SVH
`define USBPE_DEFINES_SVH

// Non-control endpoints, numbered 1 to EP_COUNT
`define EP_COUNT 3

// Endpoint number field of a token
`define EP_SEL_WID 4

// Byte wide transfers throughout
`define EP_DATA_WID 8

// 16 entries per FIFO
`define FIFO_DEPTH_LOG2 4

// Bit times to wait for the data packet
`define TIMEOUT_BITS 18

// PID byte plus two token bytes
`define TOKEN_BYTES 3

`endif
